// File: source/frame_geom_pkg.sv
package frame_geom_pkg;

	// word address into the 256K x 16 SRAM
	typedef logic [17:0] sram_addr_t;

	// one SRAM word
	// reads carry the even sample in the high byte and the odd sample in the low byte
	typedef logic [15:0] sram_word_t;

	// one Y, U, V or colour sample
	typedef logic [7:0] pixel_t;

	// first word of the packed RGB region
	localparam sram_addr_t rgb_base_addr = 18'd146944;

	// cycles from a registered address to valid read data
	localparam int sram_read_latency = 2;

	// address counter selects
	localparam logic [1:0] sel_y = 2'd0;
	localparam logic [1:0] sel_u = 2'd1;
	localparam logic [1:0] sel_v = 2'd2;
	localparam logic [1:0] sel_rgb = 2'd3;

endpackage

// File: source/csc_pkg.sv
package csc_pkg;

	// signed fixed-point intermediate
	typedef logic signed [31:0] fix_t;

	// six-tap chroma interpolation, symmetric
	localparam fix_t coef_fir_a = 21;
	localparam fix_t coef_fir_b = -52;
	localparam fix_t coef_fir_c = 159;

	// colour matrix, 16 fractional bits
	localparam fix_t coef_y = 76284;
	localparam fix_t coef_rv = 104595;
	localparam fix_t coef_gu = -25624;
	localparam fix_t coef_gv = -53281;
	localparam fix_t coef_bu = 132251;

	localparam fix_t y_offset = 16;
	localparam fix_t chroma_offset = 128;
	// half an lsb before the shift by 8
	localparam fix_t fir_round = 128;

	// what the three multipliers do this cycle
	typedef enum logic [2:0] {
		op_none,
		op_fir_v,
		op_fir_u,
		op_matrix_r_even,
		op_matrix_r_odd,
		op_matrix_gb_even,
		op_matrix_gb_odd
	} mac_op_t;

	// lead-in and pair states are numbered in the order they run
	typedef enum logic [4:0] {
		s_idle,
		s_lead_0, s_lead_1, s_lead_2, s_lead_3, s_lead_4, s_lead_5, s_lead_6, s_lead_7,
		s_pair_0, s_pair_1, s_pair_2, s_pair_3, s_pair_4, s_pair_5, s_pair_6,
		s_done
	} seq_state_t;

endpackage

// File: source/dp_ctrl_if.sv
interface dp_ctrl_if;
	import csc_pkg::*;

	// multiplier use for this cycle
	mac_op_t op;
	// lead-in window fills
	logic load_v_head;
	logic load_v_tail;
	logic load_u_head;
	logic load_u_tail;
	// one-sample window advance
	logic shift_v;
	logic shift_u;
	// low byte of the chroma word, else high byte
	logic take_odd_byte;
	// clear at the row edge, window repeats its last sample
	logic take_read;
	logic load_y;
	// 0 = {R0,G0}, 1 = {B0,R1}, 2 = {G1,B1}
	logic [1:0] write_slot;

	modport seq (output op, load_v_head, load_v_tail, load_u_head, load_u_tail,
		shift_v, shift_u, take_odd_byte, take_read, load_y, write_slot);
	modport chroma (input load_v_head, load_v_tail, load_u_head, load_u_tail,
		shift_v, shift_u, take_odd_byte, take_read);
	modport mac (input op, load_y, write_slot);

endinterface

// File: source/frame_sequencer.sv
module frame_sequencer #(
	parameter int img_width = 320,
	parameter int img_height = 240
) (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	output logic done,
	output logic write_en_n,
	output logic [1:0] addr_sel,
	output logic adv_y,
	output logic adv_u,
	output logic adv_v,
	output logic adv_rgb,
	dp_ctrl_if.seq ctrl
);
	import frame_geom_pkg::*;
	import csc_pkg::*;

	localparam int pairs_per_row = img_width / 2;
	localparam int pair_w = $clog2(pairs_per_row + 1);
	localparam int row_w = $clog2(img_height + 1);

	seq_state_t state;
	logic [pair_w-1:0] pair_cnt;
	logic [row_w-1:0] row_cnt;
	// new chroma word on every other pair
	logic chroma_toggle;
	logic last_pair;
	logic last_row;
	logic chroma_read;

	assign last_pair = (pair_cnt == pair_w'(pairs_per_row - 1));
	assign last_row = (row_cnt == row_w'(img_height - 1));
	// sample j+4 still inside the row, past that the windows clamp
	assign chroma_read = (int'(pair_cnt) + 5) <= pairs_per_row;

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			state <= s_idle;
			pair_cnt <= '0;
			row_cnt <= '0;
			chroma_toggle <= 1'b0;
			done <= 1'b0;
			write_en_n <= 1'b1;
		end else begin
			// writes go out in the cycle after their slot state
			write_en_n <= !(state inside {s_pair_2, s_pair_5, s_pair_6});
			done <= (state == s_done);
			case (state)
				s_idle: begin
					if (start) begin
						state <= s_lead_0;
					end
				end
				s_pair_6: begin
					chroma_toggle <= !chroma_toggle;
					pair_cnt <= pair_cnt + 1'b1;
					state <= s_pair_0;
					if (last_pair) begin
						pair_cnt <= '0;
						chroma_toggle <= 1'b0;
						row_cnt <= row_cnt + 1'b1;
						state <= s_lead_0;
						if (last_row) begin
							row_cnt <= '0;
							state <= s_done;
						end
					end
				end
				// last write of the frame is on the bus here
				s_done: state <= s_idle;
				default: state <= seq_state_t'(state + 5'd1);
			endcase
		end
	end

	always_comb begin
		addr_sel = sel_y;
		adv_y = 1'b0;
		adv_u = 1'b0;
		adv_v = 1'b0;
		adv_rgb = 1'b0;
		ctrl.op = op_none;
		ctrl.load_v_head = 1'b0;
		ctrl.load_v_tail = 1'b0;
		ctrl.load_u_head = 1'b0;
		ctrl.load_u_tail = 1'b0;
		ctrl.shift_v = 1'b0;
		ctrl.shift_u = 1'b0;
		ctrl.take_odd_byte = chroma_toggle;
		ctrl.take_read = chroma_read;
		ctrl.load_y = 1'b0;
		ctrl.write_slot = 2'd0;
		case (state)
			// two V words, two U words, one Y word
			s_lead_0, s_lead_1: begin
				addr_sel = sel_v;
				adv_v = 1'b1;
			end
			s_lead_2: begin
				addr_sel = sel_u;
				adv_u = 1'b1;
			end
			s_lead_3: begin
				addr_sel = sel_u;
				adv_u = 1'b1;
				ctrl.load_v_head = 1'b1;
			end
			s_lead_4: begin
				adv_y = 1'b1;
				ctrl.load_v_tail = 1'b1;
			end
			s_lead_5: ctrl.load_u_head = 1'b1;
			s_lead_6: ctrl.load_u_tail = 1'b1;
			s_lead_7: ctrl.load_y = 1'b1;
			// even pixel matrix, chroma fetch for the next window step
			s_pair_0: begin
				addr_sel = sel_v;
				adv_v = chroma_toggle && chroma_read;
				ctrl.op = op_matrix_r_even;
			end
			s_pair_1: begin
				addr_sel = sel_u;
				adv_u = chroma_toggle && chroma_read;
				ctrl.op = op_matrix_gb_even;
			end
			s_pair_2: begin
				addr_sel = sel_rgb;
				adv_rgb = 1'b1;
				ctrl.op = op_fir_v;
				ctrl.write_slot = 2'd0;
			end
			// V word from pair_0 lands, next Y pair fetched unless the row ends
			s_pair_3: begin
				adv_y = !last_pair;
				ctrl.op = op_fir_u;
				ctrl.shift_v = 1'b1;
			end
			s_pair_4: begin
				ctrl.op = op_matrix_r_odd;
				ctrl.shift_u = 1'b1;
			end
			s_pair_5: begin
				addr_sel = sel_rgb;
				adv_rgb = 1'b1;
				ctrl.op = op_matrix_gb_odd;
				ctrl.write_slot = 2'd1;
			end
			s_pair_6: begin
				addr_sel = sel_rgb;
				adv_rgb = 1'b1;
				ctrl.write_slot = 2'd2;
				ctrl.load_y = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: source/sram_addr_gen.sv
module sram_addr_gen #(
	parameter int img_width = 320,
	parameter int img_height = 240
) (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic [1:0] addr_sel,
	input logic adv_y,
	input logic adv_u,
	input logic adv_v,
	input logic adv_rgb,
	output frame_geom_pkg::sram_addr_t address
);
	import frame_geom_pkg::*;

	localparam int frame_px = img_width * img_height;
	localparam sram_addr_t u_base = sram_addr_t'(frame_px / 2);
	localparam sram_addr_t v_base = sram_addr_t'(frame_px / 2 + frame_px / 4);
	localparam sram_addr_t v_last = sram_addr_t'(frame_px - 1);
	localparam sram_addr_t rgb_last = sram_addr_t'(rgb_base_addr + frame_px * 3 / 2 - 1);

	sram_addr_t y_addr;
	sram_addr_t u_addr;
	sram_addr_t v_addr;
	sram_addr_t rgb_addr;
	sram_addr_t selected;

	// each counter falls back to its base after a full frame
	function automatic sram_addr_t step(input sram_addr_t cur, input sram_addr_t first,
		input sram_addr_t last);
		return (cur == last) ? first : cur + 1'b1;
	endfunction

	always_comb begin
		case (addr_sel)
			sel_y: selected = y_addr;
			sel_u: selected = u_addr;
			sel_v: selected = v_addr;
			default: selected = rgb_addr;
		endcase
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			y_addr <= '0;
			u_addr <= u_base;
			v_addr <= v_base;
			rgb_addr <= rgb_base_addr;
			address <= '0;
		end else begin
			address <= selected;
			if (adv_y) begin
				y_addr <= step(y_addr, '0, u_base - 1'b1);
			end
			if (adv_u) begin
				u_addr <= step(u_addr, u_base, v_base - 1'b1);
			end
			if (adv_v) begin
				v_addr <= step(v_addr, v_base, v_last);
			end
			if (adv_rgb) begin
				rgb_addr <= step(rgb_addr, rgb_base_addr, rgb_last);
			end
		end
	end

endmodule

// File: source/chroma_shift_regs.sv
module chroma_shift_regs (
	input logic CLOCK_50_I,
	input logic Resetn,
	input frame_geom_pkg::sram_word_t read_data,
	dp_ctrl_if.chroma ctrl,
	output frame_geom_pkg::pixel_t u_win [0:5],
	output frame_geom_pkg::pixel_t v_win [0:5]
);
	import frame_geom_pkg::*;

	typedef pixel_t window_t [0:5];

	// byte picked by the pair toggle
	pixel_t fresh;

	assign fresh = ctrl.take_odd_byte ? read_data[7:0] : read_data[15:8];

	// index 2 is the even sample of the current pair
	function automatic window_t next_window(
		input window_t win,
		input sram_word_t word,
		input pixel_t sample,
		input logic keep_edge,
		input logic load_head,
		input logic load_tail,
		input logic shift
	);
		window_t nxt;
		nxt = win;
		// left edge clamp by replicating sample 0
		if (load_head) begin
			nxt[0] = word[15:8];
			nxt[1] = word[15:8];
			nxt[2] = word[15:8];
			nxt[3] = word[7:0];
		end
		if (load_tail) begin
			nxt[4] = word[15:8];
			nxt[5] = word[7:0];
		end
		if (shift) begin
			for (int i = 0; i < 5; i++) begin
				nxt[i] = win[i + 1];
			end
			// right edge clamp repeats the last sample
			nxt[5] = keep_edge ? win[5] : sample;
		end
		return nxt;
	endfunction

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			u_win <= '{default: '0};
			v_win <= '{default: '0};
		end else begin
			v_win <= next_window(v_win, read_data, fresh, !ctrl.take_read,
				ctrl.load_v_head, ctrl.load_v_tail, ctrl.shift_v);
			u_win <= next_window(u_win, read_data, fresh, !ctrl.take_read,
				ctrl.load_u_head, ctrl.load_u_tail, ctrl.shift_u);
		end
	end

endmodule

// File: source/color_mac.sv
module color_mac (
	input logic CLOCK_50_I,
	input logic Resetn,
	input frame_geom_pkg::sram_word_t read_data,
	input frame_geom_pkg::pixel_t u_win [0:5],
	input frame_geom_pkg::pixel_t v_win [0:5],
	dp_ctrl_if.mac ctrl,
	output frame_geom_pkg::sram_word_t write_data
);
	import frame_geom_pkg::*;
	import csc_pkg::*;

	// operands and registered products of the three multipliers
	fix_t coef [0:2];
	fix_t sample [0:2];
	fix_t prod [0:2];
	// op that produced the current products
	mac_op_t op_q;
	pixel_t y_even;
	pixel_t y_odd;
	// interpolated chroma, may leave 0..255
	fix_t u_odd;
	fix_t v_odd;
	fix_t fir_sum;
	// luma term kept from the R step for G and B
	fix_t y_term;
	pixel_t r_keep;
	pixel_t b_keep;
	pixel_t clip_r;
	pixel_t clip_g;
	pixel_t clip_b;

	function automatic pixel_t clip_pixel(input fix_t acc);
		fix_t scaled;
		scaled = acc >>> 16;
		if (scaled < 0) begin
			return 8'd0;
		end
		if (scaled > 255) begin
			return 8'd255;
		end
		return scaled[7:0];
	endfunction

	// symmetric tap pair
	function automatic fix_t tap_pair(input pixel_t a, input pixel_t b);
		return fix_t'(a) + fix_t'(b);
	endfunction

	// operand choice per op
	always_comb begin
		coef = '{default: '0};
		sample = '{default: '0};
		case (ctrl.op)
			op_fir_v: begin
				coef = '{coef_fir_a, coef_fir_b, coef_fir_c};
				sample = '{tap_pair(v_win[0], v_win[5]), tap_pair(v_win[1], v_win[4]),
					tap_pair(v_win[2], v_win[3])};
			end
			op_fir_u: begin
				coef = '{coef_fir_a, coef_fir_b, coef_fir_c};
				sample = '{tap_pair(u_win[0], u_win[5]), tap_pair(u_win[1], u_win[4]),
					tap_pair(u_win[2], u_win[3])};
			end
			op_matrix_r_even: begin
				coef = '{coef_y, coef_rv, '0};
				sample = '{fix_t'(y_even) - y_offset, fix_t'(v_win[2]) - chroma_offset, '0};
			end
			op_matrix_r_odd: begin
				coef = '{coef_y, coef_rv, '0};
				sample = '{fix_t'(y_odd) - y_offset, v_odd - chroma_offset, '0};
			end
			op_matrix_gb_even: begin
				coef = '{coef_gu, coef_gv, coef_bu};
				sample = '{fix_t'(u_win[2]) - chroma_offset, fix_t'(v_win[2]) - chroma_offset,
					fix_t'(u_win[2]) - chroma_offset};
			end
			op_matrix_gb_odd: begin
				coef = '{coef_gu, coef_gv, coef_bu};
				sample = '{u_odd - chroma_offset, v_odd - chroma_offset, u_odd - chroma_offset};
			end
			default: ;
		endcase
	end

	assign fir_sum = (prod[0] + prod[1] + prod[2] + fir_round) >>> 8;
	// R from the r step products, G and B from the gb step plus the kept luma
	assign clip_r = clip_pixel(prod[0] + prod[1]);
	assign clip_g = clip_pixel(y_term + prod[0] + prod[1]);
	assign clip_b = clip_pixel(y_term + prod[2]);

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			op_q <= op_none;
		end else begin
			op_q <= ctrl.op;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		for (int i = 0; i < 3; i++) begin
			prod[i] <= coef[i] * sample[i];
		end
		if (ctrl.load_y) begin
			y_even <= read_data[15:8];
			y_odd <= read_data[7:0];
		end
		case (op_q)
			op_fir_v: v_odd <= fir_sum;
			op_fir_u: u_odd <= fir_sum;
			op_matrix_r_even, op_matrix_r_odd: begin
				y_term <= prod[0];
				r_keep <= clip_r;
			end
			op_matrix_gb_even, op_matrix_gb_odd: b_keep <= clip_b;
			default: ;
		endcase
		// word for the slot the sequencer names this cycle
		case (ctrl.write_slot)
			2'd0: write_data <= {r_keep, clip_g};
			2'd1: write_data <= {b_keep, clip_r};
			default: write_data <= {clip_g, clip_b};
		endcase
	end

endmodule

// File: source/yuv2rgb_top.sv
module yuv2rgb_top #(
	parameter int img_width = 320,
	parameter int img_height = 240
) (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input frame_geom_pkg::sram_word_t read_data,
	output frame_geom_pkg::sram_word_t write_data,
	output frame_geom_pkg::sram_addr_t address,
	output logic write_en_n,
	output logic done
);
	import frame_geom_pkg::*;

	logic [1:0] addr_sel;
	logic adv_y;
	logic adv_u;
	logic adv_v;
	logic adv_rgb;
	pixel_t u_win [0:5];
	pixel_t v_win [0:5];

	// per-cycle datapath commands
	dp_ctrl_if u_ctrl ();

	frame_sequencer #(
		.img_width(img_width),
		.img_height(img_height)
	) u_seq (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.start(start),
		.done(done),
		.write_en_n(write_en_n),
		.addr_sel(addr_sel),
		.adv_y(adv_y),
		.adv_u(adv_u),
		.adv_v(adv_v),
		.adv_rgb(adv_rgb),
		.ctrl(u_ctrl.seq)
	);

	sram_addr_gen #(
		.img_width(img_width),
		.img_height(img_height)
	) u_addr (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.addr_sel(addr_sel),
		.adv_y(adv_y),
		.adv_u(adv_u),
		.adv_v(adv_v),
		.adv_rgb(adv_rgb),
		.address(address)
	);

	chroma_shift_regs u_chroma (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.read_data(read_data),
		.ctrl(u_ctrl.chroma),
		.u_win(u_win),
		.v_win(v_win)
	);

	color_mac u_mac (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.read_data(read_data),
		.u_win(u_win),
		.v_win(v_win),
		.ctrl(u_ctrl.mac),
		.write_data(write_data)
	);

endmodule

// File: verif/yuv2rgb_props.sv
module yuv2rgb_props #(
	parameter int img_width = 320,
	parameter int img_height = 240
) (
	input logic CLOCK_50_I,
	input logic Resetn,
	input frame_geom_pkg::sram_addr_t address,
	input logic write_en_n,
	input logic done
);
	import frame_geom_pkg::*;

	localparam int rgb_words = img_width * img_height * 3 / 2;

	// number of failed properties
	int prop_failures = 0;

	// no write and no done right out of reset
	a_reset_idle: assert property (@(posedge CLOCK_50_I) $rose(Resetn) |-> (write_en_n && !done))
	else begin
		prop_failures++;
		$error("write or done active right after reset");
	end

	a_done_pulse: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn) done |=> !done)
	else begin
		prop_failures++;
		$error("done held longer than one cycle");
	end

	// writes only inside the RGB region
	a_write_region: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		!write_en_n |-> (address >= rgb_base_addr) && (address < rgb_base_addr + rgb_words))
	else begin
		prop_failures++;
		$error("write outside the RGB region at 0x%0h", address);
	end

	a_done_quiet: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn) done |-> write_en_n)
	else begin
		prop_failures++;
		$error("write during the done pulse");
	end

endmodule

bind yuv2rgb_top yuv2rgb_props #(
	.img_width(img_width),
	.img_height(img_height)
) u_props (
	.CLOCK_50_I(CLOCK_50_I),
	.Resetn(Resetn),
	.address(address),
	.write_en_n(write_en_n),
	.done(done)
);

// File: verif/tb_yuv2rgb.sv
module tb_yuv2rgb;
	import frame_geom_pkg::*;

	localparam int img_width = 8;
	localparam int img_height = 2;
	localparam int frame_px = img_width * img_height;
	localparam int u_base = frame_px / 2;
	localparam int v_base = u_base + frame_px / 4;
	localparam int rgb_words = img_height * img_width * 3 / 2;
	localparam int num_cases = 4;
	localparam int watchdog_cycles = num_cases * (img_height * (8 + 7 * img_width / 2) + 20) * 2;

	typedef enum int {fill_gray, fill_random, fill_extreme, fill_ramp} fill_t;
	typedef struct packed {
		fill_t fill;
		int words;
		bit expect_clip;
		bit restart_busy;
	} case_t;

	// columns are image, RGB words expected, clipped bytes required and extra start while busy
	case_t cases [0:num_cases-1] = '{
		'{fill_gray, rgb_words, 1'b0, 1'b0},
		'{fill_random, rgb_words, 1'b0, 1'b1},
		'{fill_extreme, rgb_words, 1'b1, 1'b0},
		'{fill_ramp, rgb_words, 1'b0, 1'b0}
	};

	logic CLOCK_50_I;
	logic Resetn;
	logic start;
	sram_word_t read_data;
	sram_word_t write_data;
	sram_addr_t address;
	logic write_en_n;
	logic done;

	sram_word_t mem [0:(1 << 18) - 1];
	// two-stage read pipeline
	sram_addr_t addr_d1;
	sram_addr_t addr_d2;
	sram_addr_t wr_addr_q [$];
	sram_word_t wr_data_q [$];
	sram_word_t expected [$];
	int done_count;
	int writes_at_done;

	yuv2rgb_top #(
		.img_width(img_width),
		.img_height(img_height)
	) u_dut (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.start(start),
		.read_data(read_data),
		.write_data(write_data),
		.address(address),
		.write_en_n(write_en_n),
		.done(done)
	);

	always #2 CLOCK_50_I = !CLOCK_50_I;

	// SRAM model sampled mid-cycle
	always @(negedge CLOCK_50_I) begin
		read_data <= mem[addr_d2];
		addr_d2 <= addr_d1;
		addr_d1 <= address;
		if (Resetn && !write_en_n) begin
			mem[address] <= write_data;
			wr_addr_q.push_back(address);
			wr_data_q.push_back(write_data);
		end
		if (Resetn && done) begin
			done_count++;
			writes_at_done = wr_addr_q.size();
		end
	end

	task automatic end_with_failure();
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic mismatch_error(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, sig, got, exp);
		end_with_failure();
	endtask

	task automatic problem_error(input string what);
		$display("t=%0t %s", $time, what);
		end_with_failure();
	endtask

	function automatic int luma_at(int row, int x);
		sram_word_t w;
		w = mem[row * img_width / 2 + x / 2];
		return (x % 2 == 0) ? int'(w[15:8]) : int'(w[7:0]);
	endfunction

	// chroma sample j of a row with the index held inside the row
	function automatic int chroma_at(int base, int row, int j);
		sram_word_t w;
		int k;
		k = (j < 0) ? 0 : ((j > img_width / 2 - 1) ? img_width / 2 - 1 : j);
		w = mem[base + row * img_width / 4 + k / 2];
		return (k % 2 == 0) ? int'(w[15:8]) : int'(w[7:0]);
	endfunction

	// unclipped six-tap interpolation for odd pixel 2j+1
	function automatic int interp_chroma(int base, int row, int j);
		int acc;
		acc = 21 * (chroma_at(base, row, j - 2) + chroma_at(base, row, j + 3))
			- 52 * (chroma_at(base, row, j - 1) + chroma_at(base, row, j + 2))
			+ 159 * (chroma_at(base, row, j) + chroma_at(base, row, j + 1)) + 128;
		return acc >>> 8;
	endfunction

	function automatic int clip_byte(int acc);
		int s;
		s = acc >>> 16;
		return (s < 0) ? 0 : ((s > 255) ? 255 : s);
	endfunction

	// {R,G,B} of one pixel
	function automatic logic [23:0] pixel_rgb(int y, int u, int v);
		int luma;
		int r;
		int g;
		int b;
		luma = 76284 * (y - 16);
		r = clip_byte(luma + 104595 * (v - 128));
		g = clip_byte(luma - 25624 * (u - 128) - 53281 * (v - 128));
		b = clip_byte(luma + 132251 * (u - 128));
		return {r[7:0], g[7:0], b[7:0]};
	endfunction

	task automatic build_expected();
		logic [23:0] p0;
		logic [23:0] p1;
		expected.delete();
		for (int row = 0; row < img_height; row++) begin
			for (int j = 0; j < img_width / 2; j++) begin
				p0 = pixel_rgb(luma_at(row, 2 * j), chroma_at(u_base, row, j),
					chroma_at(v_base, row, j));
				p1 = pixel_rgb(luma_at(row, 2 * j + 1), interp_chroma(u_base, row, j),
					interp_chroma(v_base, row, j));
				// {R0,G0} {B0,R1} {G1,B1}
				expected.push_back({p0[23:16], p0[15:8]});
				expected.push_back({p0[7:0], p1[23:16]});
				expected.push_back({p1[15:8], p1[7:0]});
			end
		end
	endtask

	// Y, U and V regions of the frame
	task automatic fill_frame(input fill_t fill);
		sram_word_t w;
		for (int a = 0; a < frame_px; a++) begin
			case (fill)
				fill_gray: w = 16'h8080;
				fill_random: w = 16'($urandom);
				fill_extreme: w = {a[0] ? 8'hff : 8'h00, a[1] ? 8'h00 : 8'hff};
				default: w = {8'(a * 16), 8'(a * 16 + 8)};
			endcase
			mem[a] = w;
		end
	endtask

	task automatic run_frame(input case_t tc, input int idx);
		bit saw_zero;
		bit saw_full;
		fill_frame(tc.fill);
		build_expected();
		wr_addr_q.delete();
		wr_data_q.delete();
		done_count = 0;
		@(negedge CLOCK_50_I);
		start = 1'b1;
		@(negedge CLOCK_50_I);
		start = 1'b0;
		if (tc.restart_busy) begin
			// must be ignored mid-frame
			repeat (12) @(negedge CLOCK_50_I);
			start = 1'b1;
			@(negedge CLOCK_50_I);
			start = 1'b0;
		end
		while (!done) @(negedge CLOCK_50_I);
		// room for a stray write or a second done
		repeat (4) @(negedge CLOCK_50_I);
		assert (done_count == 1)
		else problem_error($sformatf("case %0d: done pulsed %0d times", idx, done_count));
		assert (writes_at_done == tc.words)
		else mismatch_error("writes before done", writes_at_done, tc.words);
		assert (wr_addr_q.size() == tc.words)
		else mismatch_error("write count", wr_addr_q.size(), tc.words);
		saw_zero = 1'b0;
		saw_full = 1'b0;
		for (int i = 0; i < tc.words; i++) begin
			assert (wr_addr_q[i] == rgb_base_addr + i)
			else mismatch_error($sformatf("address[%0d]", i), wr_addr_q[i], rgb_base_addr + i);
			assert (wr_data_q[i] == expected[i])
			else mismatch_error($sformatf("write_data[%0d]", i), wr_data_q[i], expected[i]);
			saw_zero |= (wr_data_q[i][15:8] == 8'h00) || (wr_data_q[i][7:0] == 8'h00);
			saw_full |= (wr_data_q[i][15:8] == 8'hff) || (wr_data_q[i][7:0] == 8'hff);
		end
		assert (!tc.expect_clip || (saw_zero && saw_full))
		else problem_error($sformatf("case %0d: image never clipped to 0 and 255", idx));
	endtask

	initial begin
		CLOCK_50_I = 1'b0;
		Resetn = 1'b0;
		start = 1'b0;
		read_data = '0;
		addr_d1 = '0;
		addr_d2 = '0;
		done_count = 0;
		writes_at_done = 0;
		void'($urandom(49705));
		// background over the whole address range
		for (int a = 0; a < (1 << 18); a++) begin
			mem[a] = 16'(a) ^ 16'(a >> 3);
		end
		repeat (2) @(posedge CLOCK_50_I);
		@(negedge CLOCK_50_I);
		Resetn = 1'b1;
		// idle until the first start
		repeat (3) begin
			@(negedge CLOCK_50_I);
			assert (write_en_n === 1'b1) else mismatch_error("write_en_n", write_en_n, 1);
			assert (done === 1'b0) else mismatch_error("done", done, 0);
		end
		for (int c = 0; c < num_cases; c++) begin
			run_frame(cases[c], c);
		end
		assert (u_dut.u_props.prop_failures == 0)
		else problem_error("a bound SRAM or done property failed");
		$display("TEST PASS");
		$finish;
	end

	// bound on the total conversion time
	initial begin
		repeat (watchdog_cycles) @(posedge CLOCK_50_I);
		$display("t=%0t timeout: frames not finished after %0d cycles", $time, watchdog_cycles);
		end_with_failure();
	end

endmodule

// File: src.f
source/frame_geom_pkg.sv
source/csc_pkg.sv
source/dp_ctrl_if.sv
source/frame_sequencer.sv
source/sram_addr_gen.sv
source/chroma_shift_regs.sv
source/color_mac.sv
source/yuv2rgb_top.sv
verif/yuv2rgb_props.sv
verif/tb_yuv2rgb.sv

// File: Bender.yml
package:
  name: yuv2rgb

sources:
  - files:
      - source/frame_geom_pkg.sv
      - source/csc_pkg.sv
      - source/dp_ctrl_if.sv
      - source/frame_sequencer.sv
      - source/sram_addr_gen.sv
      - source/chroma_shift_regs.sv
      - source/color_mac.sv
      - source/yuv2rgb_top.sv
  - target: test
    files:
      - verif/yuv2rgb_props.sv
      - verif/tb_yuv2rgb.sv
